//--- Bender.yml
package:
  name: seg_display

sources:
  - files:
      - common/seg_disp_pkg.sv
      - verilog/display_timer.sv
      - verilog/retire_capture.sv
      - seg_decode/hex_seg_decoder.sv
      - seg_shift/seg_serializer.sv
      - verilog/seg_display_top.sv
  - target: test
    files:
      - verif/serial_monitor.sv
      - verif/seg_display_tb.sv

//--- common/seg_disp_pkg.sv
// package: seven-segment pattern word union, digit sizes, hex-to-segment table
package seg_disp_pkg;

	// eight digits on the board display
	localparam int SEG_DIGITS = 8;

	// bits per digit pattern
	// bit 7 = decimal point, bits 6..0 = g f e d c b a
	localparam int SEG_BITS = 8;

	// total pattern word width
	localparam int SEG_WORD_BITS = SEG_DIGITS * SEG_BITS;

	// active-high segment sets for hex digits 0..F
	// order g f e d c b a, decoder inverts for the active-low board
	localparam logic [6:0] SEG_HEX_TABLE [0:15] = '{
		7'h3f, // 0
		7'h06, // 1
		7'h5b, // 2
		7'h4f, // 3
		7'h66, // 4
		7'h6d, // 5
		7'h7d, // 6
		7'h07, // 7
		7'h7f, // 8
		7'h6f, // 9
		7'h77, // A
		7'h7c, // b
		7'h39, // C
		7'h5e, // d
		7'h79, // E
		7'h71  // F
	};

	// pattern word, seen per digit by the decoder
	// and as one flat bit string by the serializer
	// digit 7 sits in the top byte
	typedef union packed {
		logic [SEG_DIGITS-1:0][SEG_BITS-1:0] digit;
		logic [SEG_WORD_BITS-1:0]            flat;
	} seg_word_u;

endpackage

//--- list.f
common/seg_disp_pkg.sv
verilog/display_timer.sv
verilog/retire_capture.sv
seg_decode/hex_seg_decoder.sv
seg_shift/seg_serializer.sv
verilog/seg_display_top.sv
verif/serial_monitor.sv
verif/seg_display_tb.sv

//--- seg_decode/hex_seg_decoder.sv
// module hex_seg_decoder: 32-bit value to eight active-low seven-segment patterns
`timescale 1ns/10ps

module hex_seg_decoder
	import seg_disp_pkg::*;
(
	input  logic        clk200m,
	input  logic        rst_n,
	input  logic        snap_valid,
	input  logic [31:0] snap_pc,
	output seg_word_u   seg_word,
	output logic        seg_valid
);

	// one digit pattern from one nibble
	function automatic logic [SEG_BITS-1:0] hex_to_seg(input logic [3:0] nib);
		logic [6:0] segs;
		segs = SEG_HEX_TABLE[nib];
		// decimal point off, segments active low
		return {1'b1, ~segs};
	endfunction

	// combinational decode of the snapshot
	seg_word_u word_next;

	always_comb begin
		word_next = '0;
		// nibble k lands in digit k, digit 7 is the top byte
		for (int k = 0; k < SEG_DIGITS; k++) begin
			word_next.digit[k] = hex_to_seg(snap_pc[4*k +: 4]);
		end
	end

	// register the word with its strobe
	always_ff @(posedge clk200m) begin
		if (snap_valid) begin
			seg_word <= word_next;
		end
	end

	// valid follows the word, fixed latency 1
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			seg_valid <= 1'b0;
		end else begin
			seg_valid <= snap_valid;
		end
	end

endmodule

//--- seg_shift/seg_serializer.sv
// module seg_serializer: parallel pattern word to shift-register display serial lines
`timescale 1ns/10ps

module seg_serializer
	import seg_disp_pkg::*;
#(
	parameter int SHIFT_DIR = 0
) (
	input  logic      clk200m,
	input  logic      rst_n,
	input  logic      bit_tick,
	input  logic      seg_valid,
	input  seg_word_u seg_word,
	output logic      s_clk,
	output logic      s_clrn,
	output logic      sout,
	output logic      en
);

	// 0 = msb first, 1 = lsb first
	localparam bit MSB_FIRST = (SHIFT_DIR == 0);

	// state names the phase that starts at the next tick
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_SHIFT_LO,
		ST_SHIFT_HI,
		ST_LATCH
	} ser_state_e;

	ser_state_e state;

	// outgoing pattern bits
	logic [SEG_WORD_BITS-1:0] shreg;
	// bits put on sout so far, 0..64
	logic [6:0] bit_cnt;
	// next bit to present
	logic       next_bit;
	// ready for a new word
	logic       can_load;

	assign next_bit = MSB_FIRST ? shreg[SEG_WORD_BITS-1] : shreg[0];
	// wait until the latch strobe has dropped
	assign can_load = (state == ST_IDLE) && !en;

	// shift register, payload only
	always_ff @(posedge clk200m) begin
		if (can_load && seg_valid) begin
			shreg <= seg_word.flat;
		end else if (bit_tick && state == ST_SHIFT_LO) begin
			if (MSB_FIRST) begin
				shreg <= {shreg[SEG_WORD_BITS-2:0], 1'b0};
			end else begin
				shreg <= {1'b0, shreg[SEG_WORD_BITS-1:1]};
			end
		end
	end

	// control fsm and registered serial lines
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			bit_cnt <= '0;
			s_clk   <= 1'b0;
			s_clrn  <= 1'b1;
			sout    <= 1'b0;
			en      <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					// latch strobe lasts one tick period
					if (bit_tick) begin
						en <= 1'b0;
					end
					// a load while busy is dropped
					if (can_load && seg_valid) begin
						state <= ST_CLEAR;
					end
				end
				ST_CLEAR: begin
					if (bit_tick) begin
						// clear pulse marks frame start on the board
						s_clrn  <= 1'b0;
						bit_cnt <= '0;
						state   <= ST_SHIFT_LO;
					end
				end
				ST_SHIFT_LO: begin
					if (bit_tick) begin
						// data set up with serial clock low
						s_clrn  <= 1'b1;
						s_clk   <= 1'b0;
						sout    <= next_bit;
						bit_cnt <= bit_cnt + 7'd1;
						state   <= ST_SHIFT_HI;
					end
				end
				ST_SHIFT_HI: begin
					if (bit_tick) begin
						// display samples on this rising edge
						s_clk <= 1'b1;
						if (bit_cnt == 7'(SEG_WORD_BITS)) begin
							state <= ST_LATCH;
						end else begin
							state <= ST_SHIFT_LO;
						end
					end
				end
				ST_LATCH: begin
					if (bit_tick) begin
						// all 64 bits in, transfer to outputs
						s_clk <= 1'b0;
						sout  <= 1'b0;
						en    <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- verif/seg_display_tb.sv
// module seg_display_tb: clock, reset, random retire stimulus, frame model and checks
`timescale 1ns/10ps

module seg_display_tb;

	localparam int FRAME_DIV  = 600;
	localparam int NUM_FRAMES = 12;
	localparam int TIMEOUT    = 2 * FRAME_DIV;
	// eight "0" digits, dp off, segments active low
	localparam logic [63:0] ZERO_WORD = {8{8'hc0}};
	// lit segments gfedcba for hex 0..F
	localparam logic [6:0] SEG_ON [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic        clk200m;
	logic        rst_n;
	logic        wb_valid;
	logic [31:0] pc_wb;
	logic        s_clk;
	logic        s_clrn;
	logic        sout;
	logic        en;
	logic [63:0] mon_word;
	logic [7:0]  mon_bits;
	logic        frame_done;
	logic        clk_in_clear;
	logic        extra_en;
	integer      seed;
	logic        stim_on;
	// reference model state
	int unsigned cyc = 0;
	logic [31:0] last_pc = '0;
	logic [31:0] frame_pc = '0;
	logic        retired_since = 1'b0;
	logic        frame_quiet = 1'b1;
	// per-frame bookkeeping
	logic [63:0] exp_word;
	logic [63:0] prev_word;
	logic        quiet;
	int          quiet_frames;
	int          wait_cnt;

	seg_display_top #(
		.SHIFT_DIV (2),
		.FRAME_DIV (FRAME_DIV),
		.SHIFT_DIR (0),
		.PC_WIDTH  (32)
	) seg_display_top_inst (
		.clk200m (clk200m),
		.rst_n   (rst_n),
		.wb_valid(wb_valid),
		.pc_wb   (pc_wb),
		.s_clk   (s_clk),
		.s_clrn  (s_clrn),
		.sout    (sout),
		.en      (en)
	);

	serial_monitor serial_monitor_inst (
		.clk200m     (clk200m),
		.rst_n       (rst_n),
		.s_clk       (s_clk),
		.s_clrn      (s_clrn),
		.sout        (sout),
		.en          (en),
		.word        (mon_word),
		.bit_count   (mon_bits),
		.frame_done  (frame_done),
		.clk_in_clear(clk_in_clear),
		.extra_en    (extra_en)
	);

	always #5 clk200m = ~clk200m;

	// roughly one retire every 40 cycles while enabled
	always @(posedge clk200m) begin
		wb_valid <= stim_on && ($unsigned($random(seed)) % 40 == 0);
		pc_wb    <= $random(seed);
	end

	// model: frame start capture at cycle k*FRAME_DIV+1 after reset release
	always @(posedge clk200m) begin
		if (rst_n) begin
			cyc++;
			if (wb_valid) begin
				last_pc       = pc_wb;
				retired_since = 1'b1;
			end
			if (cyc > FRAME_DIV && cyc % FRAME_DIV == 1) begin
				frame_pc      = last_pc;
				frame_quiet   = !retired_since;
				retired_since = 1'b0;
			end
		end
	end

	// nibble k to digit k, dp bit 7 off, active low segments
	function automatic logic [63:0] expected_word(input logic [31:0] pc);
		logic [63:0] w;
		for (int k = 0; k < 8; k++) begin
			w[8*k +: 8] = {1'b1, ~SEG_ON[pc[4*k +: 4]]};
		end
		return w;
	endfunction

	task automatic report_mismatch(input string test, input logic [63:0] exp,
		input logic [63:0] act);
		$display("[FAIL] %s: expected %h, actual %h", test, exp, act);
		$display("sim failed");
		$fatal(1, "%s mismatch", test);
	endtask

	task automatic report_event(input string what);
		$display("[FAIL] %s", what);
		$display("sim failed");
		$fatal(1, "%s", what);
	endtask

	initial begin
		clk200m      = 1'b0;
		rst_n        = 1'b0;
		wb_valid     = 1'b0;
		pc_wb        = '0;
		stim_on      = 1'b0;
		seed         = 5;
		quiet_frames = 0;
		prev_word    = '0;
		repeat (2) @(posedge clk200m);
		rst_n <= 1'b1;
		// idle levels well before the first frame start
		for (int i = 0; i < 40; i++) begin
			@(negedge clk200m);
			assert ({s_clk, s_clrn, sout, en} == 4'b0100)
			else report_mismatch("idle after reset", 64'h4, {s_clk, s_clrn, sout, en});
		end
		for (int f = 0; f < NUM_FRAMES; f++) begin
			wait_cnt = 0;
			while (s_clrn !== 1'b0 && wait_cnt <= TIMEOUT) begin
				@(negedge clk200m);
				wait_cnt++;
			end
			if (wait_cnt > TIMEOUT) report_event("timeout waiting for s_clrn pulse");
			// snapshot of this frame is already taken
			exp_word = expected_word(frame_pc);
			quiet    = frame_quiet;
			wait_cnt = 0;
			while (frame_done !== 1'b1 && wait_cnt <= TIMEOUT) begin
				@(negedge clk200m);
				wait_cnt++;
			end
			if (wait_cnt > TIMEOUT) report_event("timeout waiting for en strobe");
			assert (mon_word == exp_word) else report_mismatch("frame word", exp_word, mon_word);
			assert (mon_bits == 8'd64) else report_mismatch("bit count", 64'd64, mon_bits);
			assert (!clk_in_clear) else report_event("s_clk rose while s_clrn was low");
			assert (!extra_en) else report_event("en pulsed more than once in a frame");
			if (f == 0) begin
				assert (mon_word == ZERO_WORD)
				else report_mismatch("word before retire", ZERO_WORD, mon_word);
			end else if (quiet) begin
				quiet_frames++;
				assert (mon_word == prev_word)
				else report_mismatch("quiet frame repeat", prev_word, mon_word);
			end
			prev_word = mon_word;
			// two frame periods without retires give one quiet frame
			stim_on = !(f == 5 || f == 6);
		end
		assert (quiet_frames > 0) else report_event("no frame without retirement was seen");
		$display("sim passed");
		$finish;
	end

endmodule

//--- verif/serial_monitor.sv
// module serial_monitor: serial line sampler that rebuilds each shifted display frame
`timescale 1ns/10ps

module serial_monitor (
	input  logic        clk200m,
	input  logic        rst_n,
	input  logic        s_clk,
	input  logic        s_clrn,
	input  logic        sout,
	input  logic        en,
	output logic [63:0] word,
	output logic [7:0]  bit_count,
	output logic        frame_done,
	output logic        clk_in_clear,
	output logic        extra_en
);

	// previous line levels for edge detection
	logic s_clk_q;
	logic s_clrn_q;
	logic en_q;
	// latch strobe already seen in this frame
	logic en_seen;

	// all lines sampled on clk200m, edges seen one cycle late
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			s_clk_q      <= 1'b0;
			s_clrn_q     <= 1'b1;
			en_q         <= 1'b0;
			en_seen      <= 1'b0;
			word         <= '0;
			bit_count    <= '0;
			frame_done   <= 1'b0;
			clk_in_clear <= 1'b0;
			extra_en     <= 1'b0;
		end else begin
			s_clk_q    <= s_clk;
			s_clrn_q   <= s_clrn;
			en_q       <= en;
			frame_done <= 1'b0;
			// clear pulse opens a new frame
			if (s_clrn_q && !s_clrn) begin
				word      <= '0;
				bit_count <= '0;
				en_seen   <= 1'b0;
			end
			// display takes sout on rising s_clk, first bit ends up on top
			if (!s_clk_q && s_clk) begin
				word      <= {word[62:0], sout};
				bit_count <= bit_count + 8'd1;
				// sticky, clock must not run during clear
				if (!s_clrn) begin
					clk_in_clear <= 1'b1;
				end
			end
			// hand over on the first latch strobe only
			if (!en_q && en) begin
				if (en_seen) begin
					extra_en <= 1'b1;
				end
				en_seen    <= 1'b1;
				frame_done <= !en_seen;
			end
		end
	end

endmodule

//--- verilog/display_timer.sv
// module display_timer: serial bit tick and frame start enables from clk200m
`timescale 1ns/10ps

module display_timer #(
	parameter int SHIFT_DIV = 4,
	parameter int FRAME_DIV = 131072
) (
	input  logic clk200m,
	input  logic rst_n,
	output logic bit_tick,
	output logic frame_start
);

	// counter widths, +1 keeps divide-by-one legal
	localparam int SW = $clog2(SHIFT_DIV + 1);
	localparam int FW = $clog2(FRAME_DIV + 1);

	logic [SW-1:0] shift_cnt;
	logic [FW-1:0] frame_cnt;
	logic          shift_wrap;
	logic          frame_wrap;

	// last count of each period
	assign shift_wrap = (shift_cnt == SW'(SHIFT_DIV - 1));
	assign frame_wrap = (frame_cnt == FW'(FRAME_DIV - 1));

	// serial rate divider
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			shift_cnt <= '0;
			bit_tick  <= 1'b0;
		end else begin
			shift_cnt <= shift_wrap ? '0 : shift_cnt + 1'b1;
			// single-cycle enable, no derived clock
			bit_tick  <= shift_wrap;
		end
	end

	// frame rate divider
	// first pulse FRAME_DIV cycles after reset release
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			frame_cnt   <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_cnt   <= frame_wrap ? '0 : frame_cnt + 1'b1;
			frame_start <= frame_wrap;
		end
	end

endmodule

//--- verilog/retire_capture.sv
// module retire_capture: last retired pc tracking and per-frame snapshot
`timescale 1ns/10ps

module retire_capture #(
	parameter int PC_WIDTH = 32
) (
	input  logic                clk200m,
	input  logic                rst_n,
	input  logic                wb_valid,
	input  logic [PC_WIDTH-1:0] pc_wb,
	input  logic                frame_start,
	output logic [31:0]         snap_pc,
	output logic                snap_valid
);

	// most recent retired pc
	logic [PC_WIDTH-1:0] pc_last;
	// pc as seen this cycle, bypassing a retire in the same cycle
	logic [PC_WIDTH-1:0] pc_now;

	// a retire coinciding with frame_start wins
	assign pc_now = wb_valid ? pc_wb : pc_last;

	// track the retire port
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			pc_last <= '0;
		end else if (wb_valid) begin
			pc_last <= pc_wb;
		end
	end

	// freeze a copy at frame start
	// later retires can't tear the value being shifted
	always_ff @(posedge clk200m) begin
		if (frame_start) begin
			// only the low 32 bits go to the display
			snap_pc <= 32'(pc_now);
		end
	end

	// snapshot valid, one cycle after frame_start
	always_ff @(posedge clk200m) begin
		if (!rst_n) begin
			snap_valid <= 1'b0;
		end else begin
			snap_valid <= frame_start;
		end
	end

endmodule

//--- verilog/seg_display_top.sv
// module seg_display_top: retired pc display path, timer, capture, decoder and serializer
`timescale 1ns/10ps

module seg_display_top
	import seg_disp_pkg::*;
#(
	parameter int SHIFT_DIV = 4,
	parameter int FRAME_DIV = 131072,
	parameter int SHIFT_DIR = 0,
	parameter int PC_WIDTH  = 32
) (
	input  logic                clk200m,
	input  logic                rst_n,
	input  logic                wb_valid,
	input  logic [PC_WIDTH-1:0] pc_wb,
	output logic                s_clk,
	output logic                s_clrn,
	output logic                sout,
	output logic                en
);

	// timing enables
	logic        bit_tick;
	logic        frame_start;
	// frozen pc per frame
	logic [31:0] snap_pc;
	logic        snap_valid;
	// decoded patterns
	seg_word_u   seg_word;
	logic        seg_valid;

	// serial and frame rates
	display_timer #(
		.SHIFT_DIV (SHIFT_DIV),
		.FRAME_DIV (FRAME_DIV)
	) display_timer_inst (
		.clk200m     (clk200m),
		.rst_n       (rst_n),
		.bit_tick    (bit_tick),
		.frame_start (frame_start)
	);

	// input side
	retire_capture #(
		.PC_WIDTH (PC_WIDTH)
	) retire_capture_inst (
		.clk200m     (clk200m),
		.rst_n       (rst_n),
		.wb_valid    (wb_valid),
		.pc_wb       (pc_wb),
		.frame_start (frame_start),
		.snap_pc     (snap_pc),
		.snap_valid  (snap_valid)
	);

	// hex to segments
	hex_seg_decoder hex_seg_decoder_inst (
		.clk200m    (clk200m),
		.rst_n      (rst_n),
		.snap_valid (snap_valid),
		.snap_pc    (snap_pc),
		.seg_word   (seg_word),
		.seg_valid  (seg_valid)
	);

	// output side
	seg_serializer #(
		.SHIFT_DIR (SHIFT_DIR)
	) seg_serializer_inst (
		.clk200m   (clk200m),
		.rst_n     (rst_n),
		.bit_tick  (bit_tick),
		.seg_valid (seg_valid),
		.seg_word  (seg_word),
		.s_clk     (s_clk),
		.s_clrn    (s_clrn),
		.sout      (sout),
		.en        (en)
	);

endmodule
